// ==== hw/tap_pkg.sv ====
// TAP controller package
// State and instruction encodings plus instruction register constants
// shared by the controller, the instruction register and the testbench

package tap_pkg;

   // ***********************************************************
   // Instruction register geometry
   // ***********************************************************
   localparam int IR_W = 8;

   // ***********************************************************
   // Controller states, classic 1149.1 encoding
   // ***********************************************************
   typedef enum logic [3:0] {
      TAP_EXIT2_DR   = 4'h0,
      TAP_EXIT1_DR   = 4'h1,
      TAP_SHIFT_DR   = 4'h2,
      TAP_PAUSE_DR   = 4'h3,
      TAP_SEL_IR     = 4'h4,
      TAP_UPDATE_DR  = 4'h5,
      TAP_CAPTURE_DR = 4'h6,
      TAP_SEL_DR     = 4'h7,
      TAP_EXIT2_IR   = 4'h8,
      TAP_EXIT1_IR   = 4'h9,
      TAP_SHIFT_IR   = 4'hA,
      TAP_PAUSE_IR   = 4'hB,
      TAP_RTI        = 4'hC,
      TAP_UPDATE_IR  = 4'hD,
      TAP_CAPTURE_IR = 4'hE,
      TAP_TLR        = 4'hF
   } tap_state_t;

   // ***********************************************************
   // Instruction opcodes
   // ***********************************************************
   // Any code not listed here decodes as bypass
   typedef enum logic [IR_W-1:0] {
      VISA_OVR = 8'h1C,
      BYPASS   = 8'hFF
   } ir_opcode_t;

   // Fixed pattern seen on TDO at the start of every IR scan
   localparam logic [IR_W-1:0] IR_CAPTURE = 8'b0000_0001;
   // Instruction after reset and in Test-Logic-Reset
   localparam ir_opcode_t IR_RESET = BYPASS;

endpackage

// ==== hw/visa_pkg.sv ====
// VISA override package
// Geometry of the override register bank and its scan chain

package visa_pkg;

   // Number of override registers in the bank
   localparam int VISA_NUM_REGS = 4;

   // Address field, sits in the top bits of the chain
   localparam int VISA_ADDR_W = 4;

   // Width of one override word, low bits of the chain
   localparam int VISA_DATA_W = 16;

   // Full chain length seen by one DR scan
   localparam int VISA_SHIFT_W = VISA_ADDR_W + VISA_DATA_W;

endpackage

// ==== hw/tap_ctrl_if.sv ====
// TAP scan control bundle
// Levels decoded from the controller state, fanned out to the
// instruction register and the data register blocks
`timescale 1ns/1ns

interface tap_ctrl_if;

   // Controller sits in Test-Logic-Reset
   logic tlr;
   // Instruction path levels
   logic capture_ir;
   logic shift_ir;
   logic update_ir;
   // Data path levels
   logic capture_dr;
   logic shift_dr;
   logic update_dr;

   modport fsm (output tlr, capture_ir, shift_ir, update_ir,
                output capture_dr, shift_dr, update_dr);

   modport ir (input tlr, capture_ir, shift_ir, update_ir);

   modport dr (input capture_dr, shift_dr, update_dr);

endinterface

// ==== hw/tap_fsm.sv ====
// TAP controller
// Sixteen-state 1149.1 state machine stepped by TMS, with decode
// of the capture, shift, update and reset levels
`timescale 1ns/1ns

module tap_fsm
   import tap_pkg::*;
(
   input  logic   atappris_tck,
   input  logic   powergoodrst_b,
   input  logic   atappris_tms,
   tap_ctrl_if.fsm ctrl
);

   tap_state_t state;
   tap_state_t next_state;

   // ***********************************************************
   // State register
   // ***********************************************************
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         state <= TAP_TLR;
      end
      else
      begin
         state <= next_state;
      end
   end

   // ***********************************************************
   // TMS transition table
   // ***********************************************************
   always_comb
   begin
      unique case (state)
         // Five ones from anywhere land here
         TAP_TLR:        next_state = atappris_tms ? TAP_TLR      : TAP_RTI;
         TAP_RTI:        next_state = atappris_tms ? TAP_SEL_DR   : TAP_RTI;
         // DR column
         TAP_SEL_DR:     next_state = atappris_tms ? TAP_SEL_IR   : TAP_CAPTURE_DR;
         TAP_CAPTURE_DR: next_state = atappris_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
         TAP_SHIFT_DR:   next_state = atappris_tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
         TAP_EXIT1_DR:   next_state = atappris_tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
         TAP_PAUSE_DR:   next_state = atappris_tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
         // Exit2 can resume shifting
         TAP_EXIT2_DR:   next_state = atappris_tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
         TAP_UPDATE_DR:  next_state = atappris_tms ? TAP_SEL_DR   : TAP_RTI;
         // IR column
         TAP_SEL_IR:     next_state = atappris_tms ? TAP_TLR      : TAP_CAPTURE_IR;
         TAP_CAPTURE_IR: next_state = atappris_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
         TAP_SHIFT_IR:   next_state = atappris_tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
         TAP_EXIT1_IR:   next_state = atappris_tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
         TAP_PAUSE_IR:   next_state = atappris_tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
         TAP_EXIT2_IR:   next_state = atappris_tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
         TAP_UPDATE_IR:  next_state = atappris_tms ? TAP_SEL_DR   : TAP_RTI;
      endcase
   end

   // ***********************************************************
   // Control level decode
   // ***********************************************************
   // Pure decode of the current state, no extra flops
   assign ctrl.tlr        = (state == TAP_TLR);

   // Instruction side
   assign ctrl.capture_ir = (state == TAP_CAPTURE_IR);
   assign ctrl.shift_ir   = (state == TAP_SHIFT_IR);
   assign ctrl.update_ir  = (state == TAP_UPDATE_IR);

   // Data side
   assign ctrl.capture_dr = (state == TAP_CAPTURE_DR);
   assign ctrl.shift_dr   = (state == TAP_SHIFT_DR);
   assign ctrl.update_dr  = (state == TAP_UPDATE_DR);

endmodule

// ==== hw/tap_ir.sv ====
// TAP instruction register
// IR shift chain, instruction latch loaded on Update-IR, and decode
// of the latched opcode into data register selects
`timescale 1ns/1ns

module tap_ir
   import tap_pkg::*;
(
   input  logic   atappris_tck,
   input  logic   powergoodrst_b,
   input  logic   atappris_tdi,
   tap_ctrl_if.ir ctrl,
   output logic   ir_so,
   output logic   sel_visa,
   output logic   sel_bypass
);

   logic [IR_W-1:0] ir_shift;
   ir_opcode_t      ir_latch;

   // ***********************************************************
   // Instruction shift chain
   // ***********************************************************
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         ir_shift <= IR_RESET;
      end
      else if (ctrl.tlr)
      begin
         ir_shift <= IR_RESET;
      end
      else if (ctrl.capture_ir)
      begin
         // Fixed capture pattern, LSB leaves first
         ir_shift <= IR_CAPTURE;
      end
      else if (ctrl.shift_ir)
      begin
         // TDI in at the MSB, toward the LSB
         ir_shift <= {atappris_tdi, ir_shift[IR_W-1:1]};
      end
   end

   // Serial out toward the TDO mux
   assign ir_so = ir_shift[0];

   // ***********************************************************
   // Instruction latch
   // ***********************************************************
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         ir_latch <= IR_RESET;
      end
      else if (ctrl.tlr)
      begin
         ir_latch <= IR_RESET;
      end
      else if (ctrl.update_ir)
      begin
         // Any code may be loaded, unknown ones included
         ir_latch <= ir_opcode_t'(ir_shift);
      end
   end

   // ***********************************************************
   // Data register select decode
   // ***********************************************************
   // One-hot by construction
   assign sel_visa   = (ir_latch == VISA_OVR);
   // Unlisted opcodes fall through to bypass
   assign sel_bypass = !sel_visa;

endmodule

// ==== hw/visa_ovr.sv ====
// VISA override data register
// Address plus data scan chain, address compare per index, and one
// holding register per index that loads on Update-DR
`timescale 1ns/1ns

module visa_ovr
   import visa_pkg::*;
(
   input  logic   atappris_tck,
   input  logic   powergoodrst_b,
   input  logic   atappris_tdi,
   tap_ctrl_if.dr ctrl,
   input  logic   sel_visa,
   output logic   visa_so,
   output logic [VISA_NUM_REGS-1:0][VISA_DATA_W-1:0] visa_ovr_data
);

   // ***********************************************************
   // Internal signals
   // ***********************************************************
   logic [VISA_SHIFT_W-1:0]  visa_shift;
   logic [VISA_ADDR_W-1:0]   shift_addr;
   logic [VISA_DATA_W-1:0]   shift_data;
   logic [VISA_NUM_REGS-1:0] addr_hit;

   // ***********************************************************
   // Scan chain
   // ***********************************************************
   // Capture loads nothing, previous contents shift back out
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         visa_shift <= '0;
      end
      else if (ctrl.shift_dr && sel_visa)
      begin
         visa_shift <= {atappris_tdi, visa_shift[VISA_SHIFT_W-1:1]};
      end
   end

   // LSB feeds the TDO mux
   assign visa_so = visa_shift[0];

   // Address rides in the top bits, data below it
   assign shift_addr = visa_shift[VISA_SHIFT_W-1 -: VISA_ADDR_W];
   assign shift_data = visa_shift[VISA_DATA_W-1:0];

   // ***********************************************************
   // Address compare
   // ***********************************************************
   // Addresses past the last index match nothing
   for (genvar i = 0; i < VISA_NUM_REGS; i++)
   begin : g_addr_cmp
      assign addr_hit[i] = (shift_addr == VISA_ADDR_W'(i));
   end

   // ***********************************************************
   // Holding registers
   // ***********************************************************
   // Written on the edge that leaves Update-DR
   // Survive Test-Logic-Reset, cleared only by power-good
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         visa_ovr_data <= '0;
      end
      else if (ctrl.update_dr && sel_visa)
      begin
         for (int r = 0; r < VISA_NUM_REGS; r++)
         begin
            if (addr_hit[r])
            begin
               visa_ovr_data[r] <= shift_data;
            end
         end
      end
   end

endmodule

// ==== hw/tdo_mux.sv ====
// TDO output stage
// Bypass bit, serial source select, and TDO plus enable retimed
// to the falling edge of the test clock
`timescale 1ns/1ns

module tdo_mux
(
   input  logic   atappris_tck,
   input  logic   powergoodrst_b,
   input  logic   atappris_tdi,
   tap_ctrl_if.dr ctrl,
   input  logic   shift_ir,
   input  logic   ir_so,
   input  logic   visa_so,
   input  logic   sel_visa,
   input  logic   sel_bypass,
   output logic   atappris_tdo,
   output logic   atappris_tdo_en
);

   logic bypass_q;
   logic tdo_next;

   // ***********************************************************
   // Bypass register
   // ***********************************************************
   // Zero captured so a bypass scan leads with a 0
   always_ff @(posedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         bypass_q <= 1'b0;
      end
      else if (ctrl.capture_dr)
      begin
         bypass_q <= 1'b0;
      end
      else if (ctrl.shift_dr)
      begin
         bypass_q <= atappris_tdi;
      end
   end

   // ***********************************************************
   // Source select
   // ***********************************************************
   always_comb
   begin
      if (shift_ir)
      begin
         tdo_next = ir_so;
      end
      else if (ctrl.shift_dr && sel_visa)
      begin
         tdo_next = visa_so;
      end
      else if (ctrl.shift_dr && sel_bypass)
      begin
         tdo_next = bypass_q;
      end
      else
      begin
         // Idle level outside the shift states
         tdo_next = 1'b0;
      end
   end

   // ***********************************************************
   // Falling edge retime
   // ***********************************************************
   // Half a cycle of setup for the capturing device
   always_ff @(negedge atappris_tck or negedge powergoodrst_b)
   begin
      if (!powergoodrst_b)
      begin
         atappris_tdo    <= 1'b0;
         atappris_tdo_en <= 1'b0;
      end
      else
      begin
         atappris_tdo    <= tdo_next;
         atappris_tdo_en <= shift_ir | ctrl.shift_dr;
      end
   end

endmodule

// ==== hw/mtap_top.sv ====
// Test access port top level
// Ties the controller, instruction register, VISA override register
// and TDO stage together behind plain pins
`timescale 1ns/1ns

module mtap_top
   import visa_pkg::*;
(
   input  logic atappris_tck,
   input  logic powergoodrst_b,
   input  logic atappris_tms,
   input  logic atappris_tdi,
   output logic atappris_tdo,
   output logic atappris_tdo_en,
   output logic [VISA_NUM_REGS-1:0][VISA_DATA_W-1:0] visa_ovr_data
);

   // ***********************************************************
   // Internal nets
   // ***********************************************************
   // Serial outputs of the two long chains
   logic ir_so;
   logic visa_so;
   // Data register selects from the instruction decode
   logic sel_visa;
   logic sel_bypass;

   // State-derived scan levels
   tap_ctrl_if i_tap_ctrl ();

   // ***********************************************************
   // Input side
   // ***********************************************************
   tap_fsm i_tap_fsm (
      .atappris_tck   (atappris_tck),
      .powergoodrst_b (powergoodrst_b),
      .atappris_tms   (atappris_tms),
      .ctrl           (i_tap_ctrl)
   );

   // ***********************************************************
   // Instruction and data registers
   // ***********************************************************
   tap_ir i_tap_ir (
      .atappris_tck   (atappris_tck),
      .powergoodrst_b (powergoodrst_b),
      .atappris_tdi   (atappris_tdi),
      .ctrl           (i_tap_ctrl),
      .ir_so          (ir_so),
      .sel_visa       (sel_visa),
      .sel_bypass     (sel_bypass)
   );

   visa_ovr i_visa_ovr (
      .atappris_tck   (atappris_tck),
      .powergoodrst_b (powergoodrst_b),
      .atappris_tdi   (atappris_tdi),
      .ctrl           (i_tap_ctrl),
      .sel_visa       (sel_visa),
      .visa_so        (visa_so),
      .visa_ovr_data  (visa_ovr_data)
   );

   // ***********************************************************
   // Output side
   // ***********************************************************
   tdo_mux i_tdo_mux (
      .atappris_tck    (atappris_tck),
      .powergoodrst_b  (powergoodrst_b),
      .atappris_tdi    (atappris_tdi),
      .ctrl            (i_tap_ctrl),
      .shift_ir        (i_tap_ctrl.shift_ir),
      .ir_so           (ir_so),
      .visa_so         (visa_so),
      .sel_visa        (sel_visa),
      .sel_bypass      (sel_bypass),
      .atappris_tdo    (atappris_tdo),
      .atappris_tdo_en (atappris_tdo_en)
   );

endmodule

// ==== tb/tb_mtap.sv ====
// Testbench for the VISA override test access port
// Walks the TAP through TMS and TDI scans, keeps a model of the
// instruction, the override bank and the VISA chain, and checks TDO
`timescale 1ns/1ns

module tb_mtap
   import tap_pkg::*, visa_pkg::*;
();

   // ***********************************************************
   // Run length and stimulus constants
   // ***********************************************************
   localparam logic [31:0] SEED = 32'hb75b73bc;
   localparam int N_WRITES    = 40;
   localparam int N_BAD       = 20;
   // Select, capture, shift, exit, update, idle and one settle cycle
   localparam int DR_SCAN_CYC = VISA_SHIFT_W + 6;
   localparam int IR_SCAN_CYC = IR_W + 6;
   localparam int TEST_CYC    = (N_WRITES + N_BAD + 8) * DR_SCAN_CYC + 4 * IR_SCAN_CYC + 32;
   localparam int MAX_CYCLES  = 2 * TEST_CYC;

   // DUT pins
   logic atappris_tck;
   logic powergoodrst_b;
   logic atappris_tms;
   logic atappris_tdi;
   logic atappris_tdo;
   logic atappris_tdo_en;
   logic [VISA_NUM_REGS-1:0][VISA_DATA_W-1:0] visa_ovr_data;

   // Reference model state
   logic [IR_W-1:0]         exp_ir;
   logic [VISA_SHIFT_W-1:0] last_shift;
   logic [VISA_NUM_REGS-1:0][VISA_DATA_W-1:0] exp_bank;

   int checks;
   int errors;
   int cycle_count;

   mtap_top i_mtap_top (
      .atappris_tck    (atappris_tck),
      .powergoodrst_b  (powergoodrst_b),
      .atappris_tms    (atappris_tms),
      .atappris_tdi    (atappris_tdi),
      .atappris_tdo    (atappris_tdo),
      .atappris_tdo_en (atappris_tdo_en),
      .visa_ovr_data   (visa_ovr_data)
   );

   // ***********************************************************
   // Clock and run limit
   // ***********************************************************
   initial
   begin
      atappris_tck = 1'b0;
      forever #20 atappris_tck = ~atappris_tck;
   end

   // Stops a scan that never returns
   always @(posedge atappris_tck)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // ***********************************************************
   // Checking and pin-level helpers
   // ***********************************************************
   task automatic check_val(input string name, input logic [63:0] exp_v,
                            input logic [63:0] act_v);
      checks++;
      assert (act_v === exp_v)
      else
      begin
         errors++;
         $display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   // One TCK with drive on the falling edge and sample on the rising edge
   // Enable seen here was registered in the state before this edge
   task automatic tck_step(input logic tms_v, input logic tdi_v, input logic exp_en,
                           output logic tdo_v);
      @(negedge atappris_tck);
      atappris_tms = tms_v;
      atappris_tdi = tdi_v;
      @(posedge atappris_tck);
      tdo_v = atappris_tdo;
      check_val("tdo_en", 64'(exp_en), 64'(atappris_tdo_en));
   endtask

   // Bank settles after the update edge and is compared half a cycle later
   task automatic check_bank(input string name);
      @(negedge atappris_tck);
      check_val(name, 64'(exp_bank), 64'(visa_ovr_data));
   endtask

   // Five ones reach Test-Logic-Reset from any state
   task automatic goto_tlr();
      logic tdo_v;
      repeat (5) tck_step(1'b1, 1'b0, 1'b0, tdo_v);
      exp_ir = IR_RESET;
   endtask

   task automatic goto_rti();
      logic tdo_v;
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
   endtask

   // ***********************************************************
   // Scan tasks that start and end in Run-Test/Idle
   // ***********************************************************
   task automatic scan_ir(input logic [IR_W-1:0] din, output logic [IR_W-1:0] dout);
      logic tdo_v;
      // Select-DR, Select-IR, Capture-IR, Shift-IR
      tck_step(1'b1, 1'b0, 1'b0, tdo_v);
      tck_step(1'b1, 1'b0, 1'b0, tdo_v);
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
      for (int i = 0; i < IR_W; i++)
      begin
         tck_step(i == IR_W - 1, din[i], 1'b1, dout[i]);
      end
      // Exit1 to Update and then back to idle
      tck_step(1'b1, 1'b0, 1'b0, tdo_v);
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
   endtask

   task automatic scan_dr(input logic [VISA_SHIFT_W-1:0] din,
                          output logic [VISA_SHIFT_W-1:0] dout);
      logic tdo_v;
      // Select-DR, Capture-DR, Shift-DR
      tck_step(1'b1, 1'b0, 1'b0, tdo_v);
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
      for (int i = 0; i < VISA_SHIFT_W; i++)
      begin
         tck_step(i == VISA_SHIFT_W - 1, din[i], 1'b1, dout[i]);
      end
      tck_step(1'b1, 1'b0, 1'b0, tdo_v);
      tck_step(1'b0, 1'b0, 1'b0, tdo_v);
   endtask

   // IR scan with capture check that also moves the model to the new opcode
   task automatic load_instr(input string name, input logic [IR_W-1:0] op);
      logic [IR_W-1:0] dout;
      scan_ir(op, dout);
      check_val({name, " ir capture"}, 64'(IR_CAPTURE), 64'(dout));
      exp_ir = op;
   endtask

   // DR scan whose expected TDO depends on the current instruction
   task automatic dr_scan_check(input string name, input logic [VISA_SHIFT_W-1:0] din);
      logic [VISA_SHIFT_W-1:0] dout;
      logic [VISA_SHIFT_W-1:0] exp_out;
      int                      addr;
      scan_dr(din, dout);
      if (exp_ir == VISA_OVR)
      begin
         // Nothing is captured so the previous chain contents come back
         exp_out = last_shift;
         last_shift = din;
         // Upper bits above the data word give the register index
         addr = int'(din[VISA_SHIFT_W-1:VISA_DATA_W]);
         for (int r = 0; r < VISA_NUM_REGS; r++)
         begin
            if (r == addr)
            begin
               exp_bank[r] = din[VISA_DATA_W-1:0];
            end
         end
      end
      else
      begin
         // Single bypass bit that clears at capture
         exp_out = {din[VISA_SHIFT_W-2:0], 1'b0};
      end
      check_val({name, " tdo"}, 64'(exp_out), 64'(dout));
      check_bank({name, " bank"});
   endtask

   // ***********************************************************
   // Test sequence
   // ***********************************************************
   initial
   begin
      void'($urandom(SEED));
      checks         = 0;
      errors         = 0;
      cycle_count    = 0;
      exp_ir         = IR_RESET;
      last_shift     = '0;
      exp_bank       = '0;
      powergoodrst_b = 1'b0;
      atappris_tms   = 1'b1;
      atappris_tdi   = 1'b0;
      repeat (2) @(negedge atappris_tck);
      powergoodrst_b = 1'b1;

      // Bank clear and bypass selected after power-good reset
      check_bank("reset bank");
      goto_tlr();
      goto_rti();
      dr_scan_check("bypass after reset", VISA_SHIFT_W'($urandom()));

      // Valid addresses write one word each
      load_instr("load visa", VISA_OVR);
      repeat (N_WRITES)
      begin
         dr_scan_check("visa write", {VISA_ADDR_W'($urandom_range(VISA_NUM_REGS - 1, 0)),
                                      VISA_DATA_W'($urandom())});
      end

      // Out of range addresses write nothing
      repeat (N_BAD)
      begin
         dr_scan_check("visa bad addr", {VISA_ADDR_W'($urandom_range(15, VISA_NUM_REGS)),
                                         VISA_DATA_W'($urandom())});
      end

      // TLR restores bypass while bank and chain keep their values
      goto_tlr();
      goto_rti();
      check_bank("bank after tlr");
      dr_scan_check("bypass after tlr", VISA_SHIFT_W'($urandom()));
      load_instr("load unknown", 8'h00);
      dr_scan_check("bypass unknown op", VISA_SHIFT_W'($urandom()));
      load_instr("reload visa", VISA_OVR);
      dr_scan_check("visa after reload", {VISA_ADDR_W'($urandom_range(VISA_NUM_REGS - 1, 0)),
                                          VISA_DATA_W'($urandom())});

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
      begin
         $display("TESTBENCH PASSED");
      end
      else
      begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== build.f ====
hw/tap_pkg.sv
hw/visa_pkg.sv
hw/tap_ctrl_if.sv
hw/tap_fsm.sv
hw/tap_ir.sv
hw/visa_ovr.sv
hw/tdo_mux.sv
hw/mtap_top.sv
tb/tb_mtap.sv

// ==== Makefile ====
# Verilator flow for the VISA override TAP

VERILATOR  ?= verilator
TOP        := tb_mtap
RTL_TOP    := mtap_top
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the log, not from the simulator exit code
run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
